//--- include/uart_bridge_settings.svh
`ifndef UART_BRIDGE_SETTINGS_SVH
`define UART_BRIDGE_SETTINGS_SVH

// flag, 7-bit address, write data
`define UB_CMD_WIDTH 16

// baud divisor register
`define UB_DIV_WIDTH 16

// 10 MHz clock at 115200 baud
`define UB_DEFAULT_DIV 87

// bit times to wait for a response start bit
`define UB_RX_TIMEOUT_BITS 32

`endif

//--- hw/uart_line_pkg.sv
`default_nettype none

`include "uart_bridge_settings.svh"

package uart_line_pkg;

  typedef enum logic {
    parity_odd  = 1'b0,
    parity_even = 1'b1
  } parity_mode_e;

  typedef enum logic [1:0] {
    rd_ok         = 2'd0,
    rd_parity_err = 2'd1,
    rd_frame_err  = 2'd2,
    rd_timeout    = 2'd3
  } read_status_e;

  // clocks per bit and parity rule, shared by tx and rx
  typedef struct packed {
    logic [`UB_DIV_WIDTH-1:0] div;
    parity_mode_e             parity;
  } line_cfg_t;

endpackage

`default_nettype wire

//--- hw/bridge_cmd_pkg.sv
`default_nettype none

`include "uart_bridge_settings.svh"

package bridge_cmd_pkg;

  // flag and data take the remaining 9 bits
  localparam int unsigned CMD_ADDR_W = `UB_CMD_WIDTH - 9;

  typedef enum logic {
    op_write = 1'b0,
    op_read  = 1'b1
  } bridge_op_e;

  typedef struct packed {
    bridge_op_e              op;
    logic [CMD_ADDR_W-1:0]   addr;
    logic [7:0]              data;
  } bridge_cmd_t;

  typedef enum logic [2:0] {
    st_idle, st_send_addr, st_send_data, st_wait_resp, st_done
  } ctrl_state_e;

endpackage

`default_nettype wire

//--- hw/uart_line_cfg.sv
`timescale 1ns/10ps
`default_nettype none

`include "uart_bridge_settings.svh"

module uart_line_cfg
  import uart_line_pkg::*;
(
  input  wire logic                     clk,
  input  wire logic                     rst_n,
  input  wire logic                     cfg_wr,
  input  wire logic [`UB_DIV_WIDTH-1:0] cfg_div,
  input  wire parity_mode_e             cfg_parity,
  input  wire logic                     cfg_lock,
  output line_cfg_t                     cfg
);

  localparam logic [`UB_DIV_WIDTH-1:0] DIV_MIN   = 2;
  localparam logic [`UB_DIV_WIDTH-1:0] DIV_RESET = `UB_DEFAULT_DIV;

  logic [`UB_DIV_WIDTH-1:0] div_next;

  // mid-bit sampling needs at least two clocks per bit
  assign div_next = (cfg_div < DIV_MIN) ? DIV_MIN : cfg_div;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg.div    <= DIV_RESET;
      cfg.parity <= parity_odd;
    end else if (cfg_wr && !cfg_lock) begin
      cfg.div    <= div_next;
      cfg.parity <= cfg_parity;
    end
  end

  a_div_min: assert property (
    @(posedge clk) disable iff (!rst_n)
    cfg.div >= DIV_MIN
  ) else $error("stored divisor below two");

endmodule

`default_nettype wire

//--- hw/uart_tx_frame.sv
`timescale 1ns/10ps
`default_nettype none

module uart_tx_frame
  import uart_line_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire line_cfg_t  cfg,
  input  wire logic       tx_start,
  input  wire logic [7:0] tx_byte,
  output logic            tx_done,
  output logic            tx
);

  logic                      busy;
  logic [3:0]                bit_idx;
  logic [$bits(cfg.div)-1:0] bit_cnt;
  logic [9:0]                shreg;
  logic                      par_bit;
  logic                      bit_end;

  // odd rule: ones over data and parity come out odd
  assign par_bit = ^tx_byte ^ (cfg.parity == parity_odd);
  assign bit_end = (bit_cnt == cfg.div - 1'b1);

  // last cycle of the stop bit
  assign tx_done = busy && bit_end && (bit_idx == 4'd10);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      bit_idx <= '0;
      bit_cnt <= '0;
      tx      <= 1'b1;
    end else if (tx_start) begin
      busy    <= 1'b1;
      bit_idx <= '0;
      bit_cnt <= '0;
      tx      <= 1'b0;
    end else if (busy) begin
      if (bit_end) begin
        bit_cnt <= '0;
        if (bit_idx == 4'd10) begin
          busy <= 1'b0;
          tx   <= 1'b1;
        end else begin
          bit_idx <= bit_idx + 1'b1;
          tx      <= shreg[0];
        end
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  // data lsb first, then parity, then stop
  always_ff @(posedge clk) begin
    if (tx_start) begin
      shreg <= {1'b1, par_bit, tx_byte};
    end else if (busy && bit_end) begin
      shreg <= {1'b1, shreg[9:1]};
    end
  end

  // a new frame may only follow on the closing stop-bit cycle
  a_no_overlap: assert property (
    @(posedge clk) disable iff (!rst_n)
    tx_start |-> (!busy || tx_done)
  ) else $error("tx_start during a frame");

  a_idle_high: assert property (
    @(posedge clk) disable iff (!rst_n)
    !busy |-> tx
  ) else $error("tx low while idle");

endmodule

`default_nettype wire

//--- hw/uart_rx_frame.sv
`timescale 1ns/10ps
`default_nettype none

`include "uart_bridge_settings.svh"

module uart_rx_frame
  import uart_line_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire line_cfg_t  cfg,
  input  wire logic       rx,
  input  wire logic       rx_arm,
  output logic            rx_done,
  output logic [7:0]      rx_byte,
  output read_status_e    rx_status
);

  typedef enum logic [1:0] {
    rx_idle, rx_hunt, rx_bits
  } rx_state_e;

  localparam int unsigned TO_W = $clog2(`UB_RX_TIMEOUT_BITS + 1);
  localparam logic [TO_W-1:0] TO_LAST = `UB_RX_TIMEOUT_BITS - 1;

  rx_state_e                 state;
  logic                      rx_meta;
  logic                      rx_sync;
  logic                      rx_prev;
  logic [$bits(cfg.div)-1:0] bit_cnt;
  logic [3:0]                bit_idx;
  logic [TO_W-1:0]           to_bits;
  logic                      par_bit;
  logic                      bit_end;
  logic                      mid_bit;
  logic                      rx_fall;
  logic                      to_expired;
  logic                      par_bad;

  assign bit_end    = (bit_cnt == cfg.div - 1'b1);
  assign mid_bit    = (bit_cnt == (cfg.div >> 1));
  assign rx_fall    = rx_prev && !rx_sync;
  assign to_expired = bit_end && (to_bits == TO_LAST);
  // ones over data and parity must match the rule
  assign par_bad    = (^{rx_byte, par_bit}) != (cfg.parity == parity_odd);

  // two-flop sync, third flop for edge detect
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= rx_idle;
      bit_cnt   <= '0;
      bit_idx   <= '0;
      to_bits   <= '0;
      rx_done   <= 1'b0;
      rx_status <= rd_ok;
    end else begin
      rx_done <= 1'b0;
      if (rx_arm) begin
        state   <= rx_hunt;
        bit_cnt <= '0;
        to_bits <= '0;
      end else begin
        case (state)
          rx_hunt: begin
            if (rx_fall) begin
              state   <= rx_bits;
              bit_cnt <= '0;
              bit_idx <= '0;
            end else if (to_expired) begin
              state     <= rx_idle;
              rx_done   <= 1'b1;
              rx_status <= rd_timeout;
            end else if (bit_end) begin
              bit_cnt <= '0;
              to_bits <= to_bits + 1'b1;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
          rx_bits: begin
            if (bit_end) begin
              bit_cnt <= '0;
              bit_idx <= bit_idx + 1'b1;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
            end
            if (mid_bit && bit_idx == 4'd0 && rx_sync) begin
              // glitch, not a start bit
              state   <= rx_hunt;
              bit_cnt <= '0;
            end else if (mid_bit && bit_idx == 4'd10) begin
              state   <= rx_idle;
              rx_done <= 1'b1;
              if (!rx_sync) begin
                rx_status <= rd_frame_err;
              end else if (par_bad) begin
                rx_status <= rd_parity_err;
              end else begin
                rx_status <= rd_ok;
              end
            end
          end
          default: state <= rx_idle;
        endcase
      end
    end
  end

  // lsb arrives first
  always_ff @(posedge clk) begin
    if (state == rx_bits && mid_bit) begin
      if (bit_idx >= 4'd1 && bit_idx <= 4'd8) begin
        rx_byte <= {rx_sync, rx_byte[7:1]};
      end
      if (bit_idx == 4'd9) begin
        par_bit <= rx_sync;
      end
    end
  end

  a_done_pulse: assert property (
    @(posedge clk) disable iff (!rst_n)
    rx_done |=> !rx_done
  ) else $error("rx_done longer than one cycle");

endmodule

`default_nettype wire

//--- hw/uart_cmd_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module uart_cmd_ctrl
  import uart_line_pkg::*;
  import bridge_cmd_pkg::*;
(
  input  wire logic         clk,
  input  wire logic         rst_n,
  input  wire logic         cmd_vld,
  input  wire bridge_cmd_t  cmd,
  output logic              cmd_rdy,
  output logic              tx_start,
  output logic [7:0]        tx_byte,
  input  wire logic         tx_done,
  output logic              rx_arm,
  input  wire logic         rx_done,
  input  wire logic [7:0]   rx_byte,
  input  wire read_status_e rx_status,
  output logic              read_vld,
  output logic [7:0]        read_data,
  output read_status_e      read_status
);

  ctrl_state_e state;
  bridge_cmd_t cmd_q;
  logic        start_q;
  logic        accept;

  // st_done is the one-cycle completion slot, ready for the next command
  assign cmd_rdy  = (state == st_idle) || (state == st_done);
  assign accept   = cmd_vld && cmd_rdy;
  assign read_vld = (state == st_done) && (cmd_q.op == op_read);

  // data frame goes out as the address stop bit ends
  assign tx_start = start_q ||
                    (state == st_send_addr && tx_done && cmd_q.op == op_write);
  assign tx_byte  = start_q ? {cmd_q.op, cmd_q.addr} : cmd_q.data;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= st_idle;
      start_q     <= 1'b0;
      rx_arm      <= 1'b0;
      read_status <= rd_ok;
    end else begin
      start_q <= 1'b0;
      rx_arm  <= 1'b0;
      case (state)
        st_idle, st_done: begin
          if (accept) begin
            state   <= st_send_addr;
            start_q <= 1'b1;
          end else begin
            state <= st_idle;
          end
        end
        st_send_addr: begin
          if (tx_done) begin
            if (cmd_q.op == op_write) begin
              state <= st_send_data;
            end else begin
              state  <= st_wait_resp;
              rx_arm <= 1'b1;
            end
          end
        end
        st_send_data: begin
          if (tx_done) begin
            state <= st_done;
          end
        end
        st_wait_resp: begin
          if (rx_done) begin
            state       <= st_done;
            read_status <= rx_status;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= cmd;
    end
    if (state == st_wait_resp && rx_done) begin
      read_data <= rx_byte;
    end
  end

  // only a read reaches the response wait
  a_read_only: assert property (
    @(posedge clk) disable iff (!rst_n)
    read_vld |-> $past(state) == st_wait_resp
  ) else $error("read_vld without a read response");

endmodule

`default_nettype wire

//--- hw/uart_bridge.sv
`timescale 1ns/10ps
`default_nettype none

`include "uart_bridge_settings.svh"

module uart_bridge
  import uart_line_pkg::*;
  import bridge_cmd_pkg::*;
(
  input  wire logic                     clk,
  input  wire logic                     rst_n,
  input  wire logic                     cfg_wr,
  input  wire logic [`UB_DIV_WIDTH-1:0] cfg_div,
  input  wire parity_mode_e             cfg_parity,
  input  wire logic                     cmd_vld,
  input  wire bridge_cmd_t              cmd,
  output logic                          cmd_rdy,
  output logic                          read_vld,
  output logic [7:0]                    read_data,
  output read_status_e                  read_status,
  output logic                          tx,
  input  wire logic                     rx
);

  line_cfg_t    cfg;
  logic         cfg_lock;
  logic         tx_start;
  logic [7:0]   tx_byte;
  logic         tx_done;
  logic         rx_arm;
  logic         rx_done;
  logic [7:0]   rx_byte;
  read_status_e rx_status;

  // line settings frozen while a command is in flight
  assign cfg_lock = ~cmd_rdy;

  uart_line_cfg u_line_cfg (
    .clk        (clk),
    .rst_n      (rst_n),
    .cfg_wr     (cfg_wr),
    .cfg_div    (cfg_div),
    .cfg_parity (cfg_parity),
    .cfg_lock   (cfg_lock),
    .cfg        (cfg)
  );

  uart_cmd_ctrl u_cmd_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_vld     (cmd_vld),
    .cmd         (cmd),
    .cmd_rdy     (cmd_rdy),
    .tx_start    (tx_start),
    .tx_byte     (tx_byte),
    .tx_done     (tx_done),
    .rx_arm      (rx_arm),
    .rx_done     (rx_done),
    .rx_byte     (rx_byte),
    .rx_status   (rx_status),
    .read_vld    (read_vld),
    .read_data   (read_data),
    .read_status (read_status)
  );

  uart_tx_frame u_tx_frame (
    .clk      (clk),
    .rst_n    (rst_n),
    .cfg      (cfg),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx_done  (tx_done),
    .tx       (tx)
  );

  uart_rx_frame u_rx_frame (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg       (cfg),
    .rx        (rx),
    .rx_arm    (rx_arm),
    .rx_done   (rx_done),
    .rx_byte   (rx_byte),
    .rx_status (rx_status)
  );

endmodule

`default_nettype wire

//--- test/tb_uart_bridge.sv
`timescale 1ns/10ps
`default_nettype none

`include "uart_bridge_settings.svh"

module tb_uart_bridge
  import uart_line_pkg::*;
  import bridge_cmd_pkg::*;
();

  localparam int RESP_GOOD   = 0;
  localparam int RESP_PARITY = 1;
  localparam int RESP_STOP   = 2;
  localparam int RESP_SILENT = 3;

  logic                     clk;
  logic                     rst_n;
  logic                     cfg_wr;
  logic [`UB_DIV_WIDTH-1:0] cfg_div;
  parity_mode_e             cfg_parity;
  logic                     cmd_vld;
  bridge_cmd_t              cmd;
  logic                     cmd_rdy;
  logic                     read_vld;
  logic [7:0]               read_data;
  read_status_e             read_status;
  logic                     tx;
  logic                     rx;

  // line settings as last written while idle
  int unsigned  cur_div;
  parity_mode_e cur_par;
  bridge_op_e   cur_op;
  read_status_e exp_status;
  logic [7:0]   exp_data;
  int           resp_mode;
  logic [7:0]   exp_stream [0:63];
  logic         exp_ends_cmd [0:63];
  int           exp_cnt;
  int           frames_seen;
  int unsigned  cycle_cnt = 0;
  logic         post_reset;
  logic         count_chk;
  int           fails;

  // decoded tx frame, one-cycle pulse
  logic         frame_vld;
  logic [7:0]   frame_byte;
  logic         frame_par_ok;
  logic         frame_stop;
  logic         frame_steady;
  int unsigned  frame_gap;
  int           frame_idx;
  logic         mon_busy;

  uart_bridge u_uart_bridge (
    .clk         (clk),
    .rst_n       (rst_n),
    .cfg_wr      (cfg_wr),
    .cfg_div     (cfg_div),
    .cfg_parity  (cfg_parity),
    .cmd_vld     (cmd_vld),
    .cmd         (cmd),
    .cmd_rdy     (cmd_rdy),
    .read_vld    (read_vld),
    .read_data   (read_data),
    .read_status (read_status),
    .tx          (tx),
    .rx          (rx)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  task automatic abort_run();
    $display("SIMULATION FAILED");
    $fatal(1, "stopping after a failure");
  endtask

  task automatic value_error(input string msg);
    fails++;
    $display("ERR %0t ns: %s", $time, msg);
    abort_run();
  endtask

  task automatic wait_expired(input string what);
    $display("timed out while waiting for %s", what);
    abort_run();
  endtask

  function automatic int unsigned wait_limit();
    return 64 * cur_div + 64;
  endfunction

  task automatic wait_ready(input string what);
    int unsigned n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!cmd_rdy && n < wait_limit());
    if (!cmd_rdy) begin
      wait_expired(what);
    end
  endtask

  task automatic await_response();
    int unsigned n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!read_vld && n < wait_limit());
    if (!read_vld) begin
      wait_expired("read_vld after a read command");
    end
  endtask

  task automatic mark_frame_count();
    count_chk <= 1'b1;
    @(posedge clk);
    count_chk <= 1'b0;
  endtask

  task automatic set_line_config(input logic [15:0] div, input parity_mode_e par);
    wait_ready("cmd_rdy before a config write");
    cfg_div    <= div;
    cfg_parity <= par;
    cfg_wr     <= 1'b1;
    @(posedge clk);
    cfg_wr  <= 1'b0;
    cur_div = div;
    cur_par = par;
  endtask

  // poke_cfg tries a config write while the command is in flight
  task automatic issue_write(input logic [6:0] addr, input logic [7:0] data,
                             input logic poke_cfg);
    wait_ready("cmd_rdy before a write");
    cur_op = op_write;
    exp_stream[exp_cnt]   = {1'b0, addr};
    exp_ends_cmd[exp_cnt] = 1'b0;
    exp_stream[exp_cnt+1]   = data;
    exp_ends_cmd[exp_cnt+1] = 1'b1;
    exp_cnt = exp_cnt + 2;
    cmd     <= '{op: op_write, addr: addr, data: data};
    cmd_vld <= 1'b1;
    @(posedge clk);
    cmd_vld <= 1'b0;
    if (poke_cfg) begin
      repeat (5) @(posedge clk);
      cfg_div    <= 16'd40;
      cfg_parity <= parity_odd;
      cfg_wr     <= 1'b1;
      @(posedge clk);
      cfg_wr <= 1'b0;
    end
    wait_ready("cmd_rdy after a write");
    mark_frame_count();
  endtask

  task automatic perform_read(input logic [6:0] addr, input int mode);
    wait_ready("cmd_rdy before a read");
    cur_op    = op_read;
    resp_mode = mode;
    exp_data  = {1'b0, addr} ^ 8'h5a;
    case (mode)
      RESP_PARITY: exp_status = rd_parity_err;
      RESP_STOP:   exp_status = rd_frame_err;
      RESP_SILENT: exp_status = rd_timeout;
      default:     exp_status = rd_ok;
    endcase
    exp_stream[exp_cnt]   = {1'b1, addr};
    exp_ends_cmd[exp_cnt] = 1'b0;
    exp_cnt = exp_cnt + 1;
    cmd     <= '{op: op_read, addr: addr, data: 8'h00};
    cmd_vld <= 1'b1;
    @(posedge clk);
    cmd_vld <= 1'b0;
    await_response();
    mark_frame_count();
  endtask

  // tx values read at the edge are the ones of the cycle just ended
  initial begin : line_monitor
    int unsigned div;
    int unsigned b;
    int unsigned c;
    int unsigned start_cyc;
    int unsigned prev_start;
    logic [10:0] bits;
    logic        steady;
    frames_seen  = 0;
    prev_start   = 0;
    frame_vld    <= 1'b0;
    frame_byte   <= '0;
    frame_par_ok <= 1'b1;
    frame_stop   <= 1'b1;
    frame_steady <= 1'b1;
    frame_gap    <= 0;
    frame_idx    <= 0;
    mon_busy     <= 1'b0;
    forever begin
      @(posedge clk);
      frame_vld <= 1'b0;
      if (rst_n && !tx) begin
        div       = cur_div;
        start_cyc = cycle_cnt;
        steady    = 1'b1;
        mon_busy <= 1'b1;
        for (b = 0; b < 11; b++) begin
          for (c = 0; c < div; c++) begin
            if (b != 0 || c != 0) begin
              @(posedge clk);
            end
            if (c == 0) begin
              bits[b] = tx;
            end else if (tx !== bits[b]) begin
              steady = 1'b0;
            end
          end
        end
        frame_vld    <= 1'b1;
        frame_byte   <= bits[8:1];
        // odd mode wants an odd count of ones over data and parity
        frame_par_ok <= ((^bits[9:1]) == (cur_par == parity_odd));
        frame_stop   <= bits[10];
        frame_steady <= steady;
        frame_gap    <= start_cyc - prev_start;
        frame_idx    <= frames_seen;
        mon_busy     <= 1'b0;
        prev_start  = start_cyc;
        frames_seen = frames_seen + 1;
      end
    end
  end

  // only the address frame of a read gets a reply
  initial begin : responder
    logic [7:0]  reply;
    logic        par;
    logic [10:0] bits;
    int unsigned b;
    rx <= 1'b1;
    forever begin
      @(posedge clk);
      if (frame_vld && cur_op == op_read && resp_mode != RESP_SILENT) begin
        reply = {1'b0, frame_byte[6:0]} ^ 8'h5a;
        par   = (^reply) ^ (cur_par == parity_odd);
        if (resp_mode == RESP_PARITY) begin
          par = ~par;
        end
        bits = {(resp_mode != RESP_STOP), par, reply, 1'b0};
        repeat (2 * cur_div) @(posedge clk);
        for (b = 0; b < 11; b++) begin
          rx <= bits[b];
          repeat (cur_div) @(posedge clk);
        end
        rx <= 1'b1;
      end
    end
  end

  initial begin : stimulus
    int unsigned rnd;
    int          i;
    rnd        = $urandom(95);
    cur_div    = `UB_DEFAULT_DIV;
    cur_par    = parity_odd;
    cur_op     = op_write;
    exp_status = rd_ok;
    exp_data   = '0;
    resp_mode  = RESP_GOOD;
    exp_cnt    = 0;
    fails      = 0;
    rst_n      <= 1'b0;
    cfg_wr     <= 1'b0;
    cfg_div    <= '0;
    cfg_parity <= parity_odd;
    cmd_vld    <= 1'b0;
    cmd        <= '0;
    post_reset <= 1'b0;
    count_chk  <= 1'b0;
    repeat (16) @(posedge clk);
    rst_n      <= 1'b1;
    post_reset <= 1'b1;
    repeat (4) @(posedge clk);
    post_reset <= 1'b0;

    for (i = 0; i < 3; i++) begin
      issue_write(7'($urandom), 8'($urandom), 1'b0);
    end
    perform_read(7'($urandom), RESP_GOOD);
    perform_read(7'($urandom), RESP_GOOD);
    perform_read(7'($urandom), RESP_PARITY);
    perform_read(7'($urandom), RESP_STOP);
    perform_read(7'($urandom), RESP_SILENT);

    // faster line, even parity
    set_line_config(16'd16, parity_even);
    issue_write(7'($urandom), 8'($urandom), 1'b1);
    issue_write(7'($urandom), 8'($urandom), 1'b0);
    perform_read(7'($urandom), RESP_GOOD);
    perform_read(7'($urandom), RESP_PARITY);
    perform_read(7'($urandom), RESP_SILENT);
    repeat (10) @(posedge clk);

    if (fails == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      abort_run();
    end
  end

  a_reset_idle: assert property (@(negedge clk)
    (!rst_n || post_reset) |-> (tx && cmd_rdy && !read_vld)
  ) else value_error("line not idle during or after reset");

  a_frame_steady: assert property (@(negedge clk) disable iff (!rst_n)
    frame_vld |-> frame_steady
  ) else value_error("tx bit changed inside its bit time");

  a_frame_stop: assert property (@(negedge clk) disable iff (!rst_n)
    frame_vld |-> frame_stop
  ) else value_error("tx stop bit low");

  a_frame_parity: assert property (@(negedge clk) disable iff (!rst_n)
    frame_vld |-> frame_par_ok
  ) else value_error("tx parity bit wrong");

  a_frame_byte: assert property (@(negedge clk) disable iff (!rst_n)
    frame_vld |-> frame_byte == exp_stream[frame_idx]
  ) else value_error("tx frame byte differs from the command");

  a_frame_end: assert property (@(negedge clk) disable iff (!rst_n)
    frame_vld |-> cmd_rdy == exp_ends_cmd[frame_idx]
  ) else value_error("cmd_rdy wrong one cycle after a stop bit");

  a_frame_gap: assert property (@(negedge clk) disable iff (!rst_n)
    (frame_vld && exp_ends_cmd[frame_idx]) |-> frame_gap == 11 * cur_div
  ) else value_error("data frame not back to back with address frame");

  a_busy_not_ready: assert property (@(negedge clk) disable iff (!rst_n)
    mon_busy |-> !cmd_rdy
  ) else value_error("cmd_rdy high while a frame is on tx");

  a_frame_count: assert property (@(negedge clk) disable iff (!rst_n)
    count_chk |-> frames_seen == exp_cnt
  ) else value_error("wrong number of tx frames for the command");

  a_read_only: assert property (@(negedge clk) disable iff (!rst_n)
    read_vld |-> cur_op == op_read
  ) else value_error("read_vld during a write command");

  a_read_status: assert property (@(negedge clk) disable iff (!rst_n)
    read_vld |-> read_status == exp_status
  ) else value_error("read_status mismatch");

  a_read_data: assert property (@(negedge clk) disable iff (!rst_n)
    (read_vld && exp_status == rd_ok) |-> read_data == exp_data
  ) else value_error("read_data mismatch");

  a_read_ready: assert property (@(negedge clk) disable iff (!rst_n)
    read_vld |-> cmd_rdy
  ) else value_error("cmd_rdy low alongside read_vld");

  a_read_pulse: assert property (@(negedge clk) disable iff (!rst_n)
    read_vld |=> !read_vld
  ) else value_error("read_vld longer than one cycle");

endmodule

`default_nettype wire

//--- uart_bridge.f
+incdir+include
hw/uart_line_pkg.sv
hw/bridge_cmd_pkg.sv
hw/uart_line_cfg.sv
hw/uart_tx_frame.sv
hw/uart_rx_frame.sv
hw/uart_cmd_ctrl.sv
hw/uart_bridge.sv
test/tb_uart_bridge.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the uart_bridge testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/tb_uart_bridge_sim

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f uart_bridge.f --top-module tb_uart_bridge -o tb_uart_bridge_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^SIMULATION PASSED$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
